// ==== tb.f ====
+incdir+logic
logic/rv_exec_pkg.sv
logic/rv_decode.sv
logic/rv_alu.sv
logic/rv_branch_cmp.sv
logic/rv_muldiv.sv
logic/rv_execute.sv
dv/tb_clock_gen.sv
dv/rv_execute_tb.sv

// ==== Makefile ====
TOP := rv_execute_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) \
		--Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== dv/rv_execute_tb.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

module rv_execute_tb;

    localparam logic [31:0] PC0 = 32'h0000_1000;
    localparam int N_RAND = 40;
    localparam int MAX_WAIT = `RV_DIV_STEPS + 10;

    logic clk, reset, in_valid, out_valid, busy, taken, illegal, table_ready;
    logic [31:0] instr, rs1_val, rs2_val, pc, result, address, ra, rb;
    int errors, checks, seed, sel;
    string t_name[$];
    logic [31:0] t_instr[$], t_rs1[$], t_rs2[$], t_pc[$], t_res[$], t_addr[$];
    logic t_taken[$], t_ill[$];
    string rand_names[11] = '{"add", "sub", "sll", "srl", "sra", "slt", "sltu",
                              "mul", "mulhu", "divu", "remu"};

    tb_clock_gen clock_gen_i (.clk(clk));

    rv_execute rv_execute_i (.clk(clk), .reset(reset), .in_valid(in_valid), .instr(instr),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .pc(pc), .out_valid(out_valid), .busy(busy),
        .result(result), .address(address), .taken(taken), .illegal(illegal));

    // ==================================================================
    // instruction encoders using rs1 = x1, rs2 = x2 and rd = x3
    // ==================================================================
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [6:0] opc,
                                           input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [19:0] imm);
        return {imm, 5'd3, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, 7'b1101111};
    endfunction

    // M ops take 2 cycles, divides and remainders the full loop
    function automatic int expected_latency(input logic [31:0] word);
        if (word[6:0] != 7'b0110011 || word[31:25] != 7'b0000001) return 1;
        return word[14] ? `RV_DIV_STEPS + 2 : 2;
    endfunction

    function automatic logic [31:0] rand_word(input int op_sel);
        case (op_sel)
            0: return r_word(7'h00, 3'd0);
            1: return r_word(7'h20, 3'd0);
            2: return r_word(7'h00, 3'd1);
            3: return r_word(7'h00, 3'd5);
            4: return r_word(7'h20, 3'd5);
            5: return r_word(7'h00, 3'd2);
            6: return r_word(7'h00, 3'd3);
            7: return r_word(7'h01, 3'd0);
            8: return r_word(7'h01, 3'd3);
            9: return r_word(7'h01, 3'd5);
            default: return r_word(7'h01, 3'd7);
        endcase
    endfunction

    function automatic logic [31:0] ref_result(input int op_sel, input logic [31:0] a, b);
        logic [63:0] prod;
        logic [`RV_SHAMT_W-1:0] sh;
        sh = b[`RV_SHAMT_W-1:0];
        prod = {32'b0, a} * {32'b0, b};
        case (op_sel)
            0: return a + b;
            1: return a - b;
            2: return a << sh;
            3: return a >> sh;
            4: return $unsigned($signed(a) >>> sh);
            5: return {31'b0, $signed(a) < $signed(b)};
            6: return {31'b0, a < b};
            7: return prod[31:0];
            8: return prod[63:32];
            9: return (b == 32'd0) ? 32'hFFFF_FFFF : a / b;
            default: return (b == 32'd0) ? a : a % b;
        endcase
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, a, b, pc_in,
                           input logic [31:0] res, addr, input logic tk, ill);
        t_name.push_back(name);
        t_instr.push_back(word);
        t_rs1.push_back(a);
        t_rs2.push_back(b);
        t_pc.push_back(pc_in);
        t_res.push_back(res);
        t_addr.push_back(addr);
        t_taken.push_back(tk);
        t_ill.push_back(ill);
    endtask

    task automatic build_table();
        add_row("add", r_word(7'h00, 3'd0), 32'd5, 32'd7, PC0, 32'd12, 0, 0, 0);
        add_row("sub", r_word(7'h20, 3'd0), 32'd5, 32'd7, PC0, 32'hFFFF_FFFE, 0, 0, 0);
        add_row("addi", i_word(3'd0, 7'h13, 12'hFFD), 32'd10, 0, PC0, 32'd7, 0, 0, 0);
        add_row("xor", r_word(7'h00, 3'd4), 32'hF0F0_F0F0, 32'hFF00_FF00, PC0,
                32'h0FF0_0FF0, 0, 0, 0);
        add_row("or", r_word(7'h00, 3'd6), 32'hF0F0_F0F0, 32'h0F00_000F, PC0,
                32'hFFF0_F0FF, 0, 0, 0);
        add_row("andi", i_word(3'd7, 7'h13, 12'h0FF), 32'h1234_5678, 0, PC0, 32'h78, 0, 0, 0);
        add_row("sll_hi_bits", r_word(7'h00, 3'd1), 32'hF, 32'h24, PC0, 32'hF0, 0, 0, 0);
        add_row("srl", r_word(7'h00, 3'd5), 32'h8000_0000, 32'h3F, PC0, 32'd1, 0, 0, 0);
        add_row("sra", r_word(7'h20, 3'd5), 32'h8000_0000, 32'h21, PC0, 32'hC000_0000, 0, 0, 0);
        add_row("srai", i_word(3'd5, 7'h13, 12'h404), 32'hF000_0000, 0, PC0,
                32'hFF00_0000, 0, 0, 0);
        add_row("slli", i_word(3'd1, 7'h13, 12'h008), 32'hAB, 0, PC0, 32'hAB00, 0, 0, 0);
        add_row("slt", r_word(7'h00, 3'd2), 32'hFFFF_FFFF, 32'd1, PC0, 32'd1, 0, 0, 0);
        add_row("sltu", r_word(7'h00, 3'd3), 32'hFFFF_FFFF, 32'd1, PC0, 32'd0, 0, 0, 0);
        add_row("slti", i_word(3'd2, 7'h13, 12'h001), 32'h8000_0000, 0, PC0, 32'd1, 0, 0, 0);
        add_row("sltiu", i_word(3'd3, 7'h13, 12'hFFF), 32'd5, 0, PC0, 32'd1, 0, 0, 0);
        add_row("lui", u_word(7'h37, 20'h12345), 0, 0, PC0, 32'h1234_5000, 0, 0, 0);
        add_row("auipc", u_word(7'h17, 20'h00001), 0, 0, PC0, 32'h2000, 0, 0, 0);
        add_row("jal_fwd", j_word(21'h100), 0, 0, PC0, 32'h1004, 32'h1100, 0, 0);
        add_row("jal_back", j_word(21'h1F_FFF8), 0, 0, PC0, 32'h1004, 32'h0FF8, 0, 0);
        add_row("jalr", i_word(3'd0, 7'h67, 12'h005), 32'h2000, 0, PC0, 32'h1004, 32'h2004,
                0, 0);
        add_row("lw", i_word(3'd2, 7'h03, 12'hFFC), 32'h3000, 0, PC0, 0, 32'h2FFC, 0, 0);
        add_row("sw", s_word(3'd2, 12'h010), 32'h3000, 32'd9, PC0, 0, 32'h3010, 0, 0);
        add_row("beq", b_word(3'd0, 13'h010), 32'd7, 32'd7, PC0, 0, 32'h1010, 1, 0);
        add_row("bne", b_word(3'd1, 13'h010), 32'd7, 32'd7, PC0, 0, 32'h1010, 0, 0);
        add_row("blt", b_word(3'd4, 13'h010), 32'hFFFF_FFFF, 32'd1, PC0, 0, 32'h1010, 1, 0);
        add_row("bge", b_word(3'd5, 13'h1FFC), 32'hFFFF_FFFF, 32'd1, PC0, 0, 32'h0FFC, 0, 0);
        add_row("bltu", b_word(3'd6, 13'h010), 32'hFFFF_FFFF, 32'd1, PC0, 0, 32'h1010, 0, 0);
        add_row("bgeu", b_word(3'd7, 13'h010), 32'hFFFF_FFFF, 32'd1, PC0, 0, 32'h1010, 1, 0);
        add_row("mul", r_word(7'h01, 3'd0), 32'hFFFF_FFFE, 32'd3, PC0, 32'hFFFF_FFFA, 0, 0, 0);
        add_row("mulh", r_word(7'h01, 3'd1), 32'h8000_0000, 32'h7FFF_FFFF, PC0,
                32'hC000_0000, 0, 0, 0);
        add_row("mulhsu", r_word(7'h01, 3'd2), 32'hFFFF_FFFF, 32'hFFFF_FFFF, PC0,
                32'hFFFF_FFFF, 0, 0, 0);
        add_row("mulhu", r_word(7'h01, 3'd3), 32'hFFFF_FFFF, 32'hFFFF_FFFF, PC0,
                32'hFFFF_FFFE, 0, 0, 0);
        add_row("div", r_word(7'h01, 3'd4), 32'hFFFF_FFF9, 32'd2, PC0, 32'hFFFF_FFFD, 0, 0, 0);
        add_row("rem", r_word(7'h01, 3'd6), 32'hFFFF_FFF9, 32'd2, PC0, 32'hFFFF_FFFF, 0, 0, 0);
        add_row("divu_zero", r_word(7'h01, 3'd5), 32'h1234, 0, PC0, 32'hFFFF_FFFF, 0, 0, 0);
        add_row("rem_zero", r_word(7'h01, 3'd6), 32'hFFFF_FFF9, 0, PC0, 32'hFFFF_FFF9, 0, 0, 0);
        add_row("div_ovf", r_word(7'h01, 3'd4), 32'h8000_0000, 32'hFFFF_FFFF, PC0,
                32'h8000_0000, 0, 0, 0);
        add_row("rem_ovf", r_word(7'h01, 3'd6), 32'h8000_0000, 32'hFFFF_FFFF, PC0, 0, 0, 0, 0);
        add_row("illegal", 32'hFFFF_FFFF, 32'd3, 32'd4, PC0, 0, 0, 0, 1);
        // load opcode with an unused width, would otherwise give an address
        add_row("illegal_ld", i_word(3'd3, 7'h03, 12'h010), 32'h3000, 0, PC0, 0, 0, 0, 1);
    endtask

    task automatic check_word(input string name, input string field,
                              input logic [31:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    // ==================================================================
    // one strobe, then wait for out_valid and compare
    // ==================================================================
    task automatic run_op(input string name, input logic [31:0] word, a, b, pc_in,
                          input logic [31:0] exp_res, exp_addr, input logic exp_tk, exp_ill);
        int lat;
        int want_lat;
        logic is_mdu;
        logic seen;
        want_lat = expected_latency(word);
        is_mdu = (want_lat > 1);
        @(posedge clk);
        in_valid <= 1'b1;
        instr <= word;
        rs1_val <= a;
        rs2_val <= b;
        pc <= pc_in;
        lat = 0;
        seen = 1'b0;
        while (!seen && lat < MAX_WAIT) begin
            @(posedge clk);
            in_valid <= 1'b0;
            lat++;
            @(negedge clk);   // outputs settled here
            if (busy !== is_mdu) begin
                errors++;
                $display("FAILED %s busy at cycle %0d: expected %b, actual %b",
                         name, lat, is_mdu, busy);
            end
            seen = out_valid;
        end
        if (!seen) begin
            errors++;
            $display("no out_valid for %s within %0d cycles", name, MAX_WAIT);
        end else begin
            check_word(name, "result", exp_res, result);
            check_word(name, "address", exp_addr, address);
            check_word(name, "taken", {31'b0, exp_tk}, {31'b0, taken});
            check_word(name, "illegal", {31'b0, exp_ill}, {31'b0, illegal});
            check_word(name, "latency", want_lat, lat);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        seed = 67;
        table_ready = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        rs1_val = '0;
        rs2_val = '0;
        pc = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        foreach (t_instr[i]) begin
            run_op(t_name[i], t_instr[i], t_rs1[i], t_rs2[i], t_pc[i], t_res[i], t_addr[i],
                   t_taken[i], t_ill[i]);
        end

        for (int i = 0; i < N_RAND; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            sel = $unsigned($random(seed)) % 11;
            if (i % 8 == 5) rb = '0;   // hit divide by zero now and then
            run_op($sformatf("rand%0d_%s", i, rand_names[sel]), rand_word(sel), ra, rb, PC0,
                   ref_result(sel, ra, rb), 32'd0, 1'b0, 1'b0);
        end

        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // budget covers a full divide for every operation
    initial begin
        wait (table_ready);
        repeat ((t_instr.size() + N_RAND) * (`RV_DIV_STEPS + 10) + 10) @(posedge clk);
        $display("timeout: the run did not finish within its cycle budget");
        $display("%0d checks, %0d errors", checks, errors + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk
);

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;   // 10 unit period

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

module rv_execute (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  in_valid,
    input  wire [31:0]           instr,
    input  wire [`RV_XLEN-1:0]   rs1_val,
    input  wire [`RV_XLEN-1:0]   rs2_val,
    input  wire [`RV_XLEN-1:0]   pc,
    output logic                 out_valid,
    output logic                 busy,
    output logic [`RV_XLEN-1:0]  result,
    output logic [`RV_XLEN-1:0]  address,
    output logic                 taken,
    output logic                 illegal
);
    import rv_exec_pkg::*;

    alu_op_e             dec_op;
    mdu_op_e             dec_mdu_op;
    br_cond_e            dec_br_cond;
    exec_unit_e          dec_unit;
    logic [`RV_XLEN-1:0] dec_imm;
    logic                dec_use_imm;
    logic                dec_illegal;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] alu_address;
    logic                br_taken;
    logic                alu_strobe;
    logic                mdu_start;
    logic                mdu_done;
    logic [`RV_XLEN-1:0] mdu_result;
    logic                valid_q;
    logic [`RV_XLEN-1:0] result_q;
    logic [`RV_XLEN-1:0] address_q;
    logic                taken_q;
    logic                illegal_q;

    rv_decode rv_decode_i (.instr(instr), .op(dec_op), .mdu_op(dec_mdu_op),
        .br_cond(dec_br_cond), .unit(dec_unit), .imm(dec_imm), .use_imm(dec_use_imm),
        .illegal(dec_illegal));

    rv_alu rv_alu_i (.op(dec_op), .use_imm(dec_use_imm), .rs1_val(rs1_val),
        .rs2_val(rs2_val), .imm(dec_imm), .pc(pc), .result(alu_result),
        .address(alu_address));

    rv_branch_cmp rv_branch_cmp_i (.cond(dec_br_cond), .rs1_val(rs1_val),
        .rs2_val(rs2_val), .taken(br_taken));

    rv_muldiv rv_muldiv_i (.clk(clk), .reset(reset), .start(mdu_start), .op(dec_mdu_op),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .done(mdu_done), .result(mdu_result));

    assign alu_strobe = in_valid && (dec_unit == unit_alu);
    assign mdu_start  = in_valid && (dec_unit == unit_mdu);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            busy      <= 1'b0;
            result_q  <= '0;
            address_q <= '0;
            taken_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q <= alu_strobe;
            if (mdu_start) busy <= 1'b1;
            else if (mdu_done) busy <= 1'b0;   // drops the cycle after out_valid
            if (alu_strobe) begin
                result_q  <= alu_result;
                address_q <= alu_address;
                taken_q   <= br_taken && (dec_op == alu_branch);
                illegal_q <= dec_illegal;
            end else if (mdu_done) begin
                result_q  <= mdu_result;
                address_q <= '0;
                taken_q   <= 1'b0;
                illegal_q <= 1'b0;
            end
        end
    end

    // M results are forwarded in their done cycle, then held
    assign out_valid = valid_q || mdu_done;
    assign result    = mdu_done ? mdu_result : result_q;
    assign address   = mdu_done ? '0 : address_q;
    assign taken     = taken_q && !mdu_done;
    assign illegal   = illegal_q && !mdu_done;

    assert property (@(posedge clk) disable iff (reset) busy |-> !in_valid);

    // a second pulse needs a fresh ALU strobe behind it
    assert property (@(posedge clk) disable iff (reset)
        (out_valid && !alu_strobe) |=> !out_valid);

endmodule

`default_nettype wire

// ==== logic/rv_muldiv.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

module rv_muldiv (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       start,
    input  wire rv_exec_pkg::mdu_op_e op,
    input  wire [`RV_XLEN-1:0]        rs1_val,
    input  wire [`RV_XLEN-1:0]        rs2_val,
    output logic                      done,
    output logic [`RV_XLEN-1:0]       result
);
    import rv_exec_pkg::*;

    localparam int CNT_W = $clog2(`RV_DIV_STEPS + 1);

    mdu_op_e                       op_q;
    logic                          mul_s1;
    logic                          div_run;
    logic                          div_fix;
    logic [CNT_W-1:0]              step_cnt;
    logic                          is_div;
    logic                          a_signed;
    logic                          b_signed;
    logic signed [`RV_XLEN:0]      mul_a;
    logic signed [`RV_XLEN:0]      mul_b;
    logic signed [2*`RV_XLEN+1:0]  prod_q;
    logic [`RV_XLEN-1:0]           dvd_mag;
    logic [`RV_XLEN-1:0]           dvs_mag;
    logic [`RV_XLEN-1:0]           rem_q;
    logic [`RV_XLEN-1:0]           quot_q;
    logic [`RV_XLEN-1:0]           dvs_q;
    logic                          neg_quot_q;
    logic                          neg_rem_q;
    logic [`RV_XLEN:0]             rem_shift;
    logic [`RV_XLEN:0]             trial;

    assign is_div   = op inside {mdu_div, mdu_divu, mdu_rem, mdu_remu};
    assign a_signed = op inside {mdu_mulh, mdu_mulhsu, mdu_div, mdu_rem};
    assign b_signed = op inside {mdu_mulh, mdu_div, mdu_rem};

    // 33-bit operands cover every signed/unsigned mix
    assign mul_a = {a_signed & rs1_val[`RV_XLEN-1], rs1_val};
    assign mul_b = {b_signed & rs2_val[`RV_XLEN-1], rs2_val};

    assign dvd_mag = (a_signed && rs1_val[`RV_XLEN-1]) ? -rs1_val : rs1_val;
    assign dvs_mag = (b_signed && rs2_val[`RV_XLEN-1]) ? -rs2_val : rs2_val;

    assign rem_shift = {rem_q, quot_q[`RV_XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_s1   <= 1'b0;
            div_run  <= 1'b0;
            div_fix  <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            mul_s1  <= start && !is_div;
            div_fix <= div_run && (step_cnt == CNT_W'(1));
            done    <= mul_s1 || div_fix;
            if (start && is_div) begin
                div_run  <= 1'b1;
                step_cnt <= CNT_W'(`RV_DIV_STEPS);
            end else if (div_run) begin
                step_cnt <= step_cnt - 1'b1;
                if (step_cnt == CNT_W'(1)) div_run <= 1'b0;
            end
        end
    end

    // ==================================================================
    // datapath: product pipe, shift-subtract loop, sign fix
    // ==================================================================
    always_ff @(posedge clk) begin
        if (start) begin
            op_q       <= op;
            prod_q     <= mul_a * mul_b;
            rem_q      <= '0;
            quot_q     <= dvd_mag;
            dvs_q      <= dvs_mag;
            // x/0 keeps the all-ones quotient unsigned
            neg_quot_q <= a_signed && (rs1_val[`RV_XLEN-1] ^ rs2_val[`RV_XLEN-1]) &&
                          (rs2_val != '0);
            neg_rem_q  <= a_signed && rs1_val[`RV_XLEN-1];
        end else if (div_run) begin
            if (!trial[`RV_XLEN]) begin
                rem_q  <= trial[`RV_XLEN-1:0];
                quot_q <= {quot_q[`RV_XLEN-2:0], 1'b1};
            end else begin
                rem_q  <= rem_shift[`RV_XLEN-1:0];   // restore
                quot_q <= {quot_q[`RV_XLEN-2:0], 1'b0};
            end
        end

        if (mul_s1) begin
            result <= (op_q == mdu_mul) ? prod_q[`RV_XLEN-1:0] : prod_q[2*`RV_XLEN-1:`RV_XLEN];
        end else if (div_fix) begin
            if (op_q == mdu_rem || op_q == mdu_remu) result <= neg_rem_q ? -rem_q : rem_q;
            else result <= neg_quot_q ? -quot_q : quot_q;
        end
    end

    // done only ever follows a start by the multiply or divide latency
    assert property (@(posedge clk) disable iff (reset)
        done |-> $past(start, 2) || $past(start, `RV_DIV_STEPS + 2));

    assert property (@(posedge clk) disable iff (reset)
        start |-> !(mul_s1 || div_run || div_fix));

endmodule

`default_nettype wire

// ==== logic/rv_branch_cmp.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

module rv_branch_cmp (
    input  wire rv_exec_pkg::br_cond_e cond,
    input  wire [`RV_XLEN-1:0]         rs1_val,
    input  wire [`RV_XLEN-1:0]         rs2_val,
    output logic                       taken
);
    import rv_exec_pkg::*;

    logic is_eq;
    logic is_lt_s;
    logic is_lt_u;

    // three comparators shared by all six conditions
    assign is_eq   = (rs1_val == rs2_val);
    assign is_lt_s = ($signed(rs1_val) < $signed(rs2_val));
    assign is_lt_u = (rs1_val < rs2_val);

    always_comb begin
        case (cond)
            br_beq:  taken = is_eq;
            br_bne:  taken = !is_eq;
            br_blt:  taken = is_lt_s;
            br_bge:  taken = !is_lt_s;
            br_bltu: taken = is_lt_u;
            br_bgeu: taken = !is_lt_u;
            default: taken = 1'b0;   // 010/011 are not branches
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

module rv_alu (
    input  wire rv_exec_pkg::alu_op_e op,
    input  wire                       use_imm,
    input  wire [`RV_XLEN-1:0]        rs1_val,
    input  wire [`RV_XLEN-1:0]        rs2_val,
    input  wire [`RV_XLEN-1:0]        imm,
    input  wire [`RV_XLEN-1:0]        pc,
    output logic [`RV_XLEN-1:0]       result,
    output logic [`RV_XLEN-1:0]       address
);
    import rv_exec_pkg::*;

    logic [`RV_XLEN-1:0]   operand_b;
    logic [`RV_SHAMT_W-1:0] shamt;
    logic [2*`RV_XLEN-1:0] sext_rs1;
    logic [2*`RV_XLEN-1:0] sra_full;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic [`RV_XLEN-1:0]   pc_plus4;
    logic [`RV_XLEN-1:0]   jalr_target;

    assign operand_b = use_imm ? imm : rs2_val;
    assign shamt     = operand_b[`RV_SHAMT_W-1:0];   // upper bits of rs2 ignored

    // arithmetic shift done on a sign-extended double word
    assign sext_rs1 = {{`RV_XLEN{rs1_val[`RV_XLEN-1]}}, rs1_val};
    assign sra_full = sext_rs1 >> shamt;

    // signed order flips the unsigned one when the signs differ
    assign lt_unsigned = (rs1_val < operand_b);
    assign lt_signed   = lt_unsigned ^ (rs1_val[`RV_XLEN-1] != operand_b[`RV_XLEN-1]);

    assign pc_plus4    = pc + `RV_XLEN'd4;
    assign jalr_target = rs1_val + imm;

    // ==================================================================
    // result and address select
    // ==================================================================
    always_comb begin
        result  = '0;
        address = '0;   // only jumps, branches and memory ops drive this

        case (op)
            alu_add:   result = rs1_val + operand_b;
            alu_sub:   result = rs1_val - operand_b;
            alu_sll:   result = rs1_val << shamt;
            alu_slt:   result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            alu_sltu:  result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            alu_xor:   result = rs1_val ^ operand_b;
            alu_srl:   result = rs1_val >> shamt;
            alu_sra:   result = sra_full[`RV_XLEN-1:0];
            alu_or:    result = rs1_val | operand_b;
            alu_and:   result = rs1_val & operand_b;
            alu_lui:   result = imm;
            alu_auipc: result = pc + imm;
            alu_jal: begin
                result  = pc_plus4;
                address = pc + imm;
            end
            alu_jalr: begin
                result  = pc_plus4;
                address = {jalr_target[`RV_XLEN-1:1], 1'b0};   // bit 0 dropped
            end
            alu_branch: address = pc + imm;
            alu_mem:    address = rs1_val + imm;
            default: begin
                result  = '0;
                address = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rv_decode.sv ====
`default_nettype none

`include "rv_exec_macros.svh"

module rv_decode (
    input  wire [31:0]                instr,
    output rv_exec_pkg::alu_op_e      op,
    output rv_exec_pkg::mdu_op_e      mdu_op,
    output rv_exec_pkg::br_cond_e     br_cond,
    output rv_exec_pkg::exec_unit_e   unit,
    output logic [`RV_XLEN-1:0]       imm,
    output logic                      use_imm,
    output logic                      illegal
);
    import rv_exec_pkg::*;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ==================================================================
    // immediate formats, all sign-extended from bit 31
    // ==================================================================
    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        op      = alu_nop;
        mdu_op  = mdu_op_e'(funct3);
        br_cond = br_cond_e'(funct3);   // masked by the top unless a branch
        unit    = unit_alu;
        imm     = '0;
        use_imm = 1'b0;
        illegal = 1'b0;

        case (opcode)
            7'b0110111: begin op = alu_lui;   imm = imm_u; end
            7'b0010111: begin op = alu_auipc; imm = imm_u; end
            7'b1101111: begin op = alu_jal;   imm = imm_j; end
            7'b1100111: begin
                op      = alu_jalr;
                imm     = imm_i;
                illegal = (funct3 != 3'b000);
            end
            7'b1100011: begin
                op      = alu_branch;
                imm     = imm_b;
                illegal = (funct3[2:1] == 2'b01);   // 010 and 011 unused
            end
            7'b0000011: begin
                op      = alu_mem;
                imm     = imm_i;
                illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            7'b0100011: begin
                op      = alu_mem;
                imm     = imm_s;
                illegal = funct3[2] || (funct3 == 3'b011);
            end
            7'b0010011: begin
                imm     = imm_i;
                use_imm = 1'b1;
                case (funct3)
                    3'b000: op = alu_add;
                    3'b001: begin op = alu_sll; illegal = (funct7 != 7'b0000000); end
                    3'b010: op = alu_slt;
                    3'b011: op = alu_sltu;
                    3'b100: op = alu_xor;
                    3'b101: begin
                        op      = funct7[5] ? alu_sra : alu_srl;
                        illegal = ((funct7 & 7'b1011111) != 7'b0000000);
                    end
                    3'b110: op = alu_or;
                    default: op = alu_and;
                endcase
            end
            7'b0110011: begin
                if (funct7 == 7'b0000001) begin
                    unit = unit_mdu;
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op = alu_add;
                        3'b001: op = alu_sll;
                        3'b010: op = alu_slt;
                        3'b011: op = alu_sltu;
                        3'b100: op = alu_xor;
                        3'b101: op = alu_srl;
                        3'b110: op = alu_or;
                        default: op = alu_and;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = alu_sub;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    op = alu_sra;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase

        // anything unknown retires as a plain nop
        if (illegal) begin
            op      = alu_nop;
            unit    = unit_alu;
            imm     = '0;
            use_imm = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    // ==================================================================
    // alu operations, I-type forms share the R-type codes
    // ==================================================================
    typedef enum logic [4:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_lui,
        alu_auipc,
        alu_jal,
        alu_jalr,
        alu_branch,
        alu_mem     // loads and stores, address only
    } alu_op_e;

    // M extension, encoded as funct3
    typedef enum logic [2:0] {
        mdu_mul    = 3'b000,
        mdu_mulh   = 3'b001,
        mdu_mulhsu = 3'b010,
        mdu_mulhu  = 3'b011,
        mdu_div    = 3'b100,
        mdu_divu   = 3'b101,
        mdu_rem    = 3'b110,
        mdu_remu   = 3'b111
    } mdu_op_e;

    // branch conditions straight from funct3
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_cond_e;

    typedef enum logic {
        unit_alu,
        unit_mdu
    } exec_unit_e;

endpackage

`default_nettype wire

// ==== logic/rv_exec_macros.svh ====
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// ======================================================================
// execute stage sizing
// ======================================================================

// integer register width
`define RV_XLEN 32

// register shifts honour only this many low bits of the amount
`define RV_SHAMT_W 5

// restoring divider retires one quotient bit per cycle
`define RV_DIV_STEPS `RV_XLEN

`endif
